//--- common/regReadPkg.sv
/*
 * Register-read stage shared sizes and the payload word carried to execute.
 */
package regReadPkg;

  // ********************
  // Default sizes
  // ********************

  // Issue lanes per cycle.
  localparam int DEF_NUM_LANES = 4;

  // Physical register count.
  localparam int DEF_NUM_PHYS = 64;

  // Registers mapped after reset.
  localparam int DEF_NUM_ARCH = 32;

  // Operand width.
  localparam int DEF_DATA_W = 32;

  // Branch checkpoints, also the mask width.
  localparam int DEF_NUM_CKPT = 4;

  // ********************
  // Payload
  // ********************

  // Pass-through word width.
  localparam int PAYLOAD_W = 16;

  // The payload holds the opcode and the active-list index of the issued
  // instruction and reaches execute unchanged.
  typedef struct packed {
    logic [PAYLOAD_W/2-1:0] opcode;
    logic [PAYLOAD_W/2-1:0] alIndex;
  } payload_t;

endpackage

//--- regfile/physRegFile.sv
/*
 * Physical register file with one write port and two combinational read
 * ports per issue lane.
 */
`timescale 1ns/1ps

module physRegFile #(
  parameter int NUM_LANES = regReadPkg::DEF_NUM_LANES,
  parameter int NUM_PHYS  = regReadPkg::DEF_NUM_PHYS,
  parameter int DATA_W    = regReadPkg::DEF_DATA_W,
  localparam int TAG_W    = $clog2(NUM_PHYS)
) (
  input  logic                              clk,
  input  logic                              rstN_i,
  input  logic [NUM_LANES-1:0]              wrEn_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]   wrTag_i,
  input  logic [NUM_LANES-1:0][DATA_W-1:0]  wrData_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]   rdTag1_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]   rdTag2_i,
  output logic [NUM_LANES-1:0][DATA_W-1:0]  rdData1_o,
  output logic [NUM_LANES-1:0][DATA_W-1:0]  rdData2_o
);

  logic [DATA_W-1:0] regArray [NUM_PHYS];

  // ********************
  // Write ports
  // ********************

  // Lanes are applied in order, so the highest lane wins a collision.
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int p = 0; p < NUM_PHYS; p++) begin
        regArray[p] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_LANES; w++) begin
        if (wrEn_i[w]) begin
          regArray[wrTag_i[w]] <= wrData_i[w];
        end
      end
    end
  end

  // ********************
  // Read ports
  // ********************

  // Reads see the array as it stood at the last edge.
  // Same-cycle write data is picked up by the lane forwarding logic.
  always_comb begin
    for (int r = 0; r < NUM_LANES; r++) begin
      rdData1_o[r] = regArray[rdTag1_i[r]];
      rdData2_o[r] = regArray[rdTag2_i[r]];
    end
  end

endmodule

//--- verilog/readLane.sv
/*
 * One issue lane of the register-read stage: operand forwarding from the
 * write-back buses, mispredict squash and the output register to execute.
 */
`timescale 1ns/1ps

module readLane #(
  parameter int NUM_LANES = regReadPkg::DEF_NUM_LANES,
  parameter int NUM_PHYS  = regReadPkg::DEF_NUM_PHYS,
  parameter int DATA_W    = regReadPkg::DEF_DATA_W,
  parameter int NUM_CKPT  = regReadPkg::DEF_NUM_CKPT,
  localparam int TAG_W    = $clog2(NUM_PHYS)
) (
  input  logic                              clk,
  input  logic                              rstN_i,
  input  logic                              issueValid_i,
  input  logic [TAG_W-1:0]                  srcTag1_i,
  input  logic [TAG_W-1:0]                  srcTag2_i,
  input  logic [NUM_CKPT-1:0]               ckptMask_i,
  input  regReadPkg::payload_t              payload_i,
  input  logic [DATA_W-1:0]                 rfData1_i,
  input  logic [DATA_W-1:0]                 rfData2_i,
  input  logic [NUM_LANES-1:0]              wbValid_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]   wbTag_i,
  input  logic [NUM_LANES-1:0][DATA_W-1:0]  wbData_i,
  input  logic [NUM_CKPT-1:0]               killCkpt_i,
  output logic                              outValid_o,
  output logic [DATA_W-1:0]                 outData1_o,
  output logic [DATA_W-1:0]                 outData2_o,
  output regReadPkg::payload_t              outPayload_o
);

  import regReadPkg::*;

  logic [NUM_LANES-1:0] hit1;
  logic [NUM_LANES-1:0] hit2;
  logic [DATA_W-1:0]    operand1;
  logic [DATA_W-1:0]    operand2;
  logic                 killed;
  logic                 laneValid;
  logic                 validQ;
  logic [DATA_W-1:0]    data1Q;
  logic [DATA_W-1:0]    data2Q;
  payload_t             payloadQ;

  // Lowest matching lane wins, otherwise the register file value.
  function automatic logic [DATA_W-1:0] pickOperand(
    input logic [NUM_LANES-1:0]              hit,
    input logic [NUM_LANES-1:0][DATA_W-1:0]  wbData,
    input logic [DATA_W-1:0]                 rfData
  );
    logic [DATA_W-1:0] value;
    value = rfData;
    for (int w = NUM_LANES - 1; w >= 0; w--) begin
      if (hit[w]) begin
        value = wbData[w];
      end
    end
    return value;
  endfunction

  // ********************
  // Forwarding
  // ********************

  always_comb begin
    for (int w = 0; w < NUM_LANES; w++) begin
      hit1[w] = wbValid_i[w] && (wbTag_i[w] == srcTag1_i);
      hit2[w] = wbValid_i[w] && (wbTag_i[w] == srcTag2_i);
    end
  end

  assign operand1 = pickOperand(hit1, wbData_i, rfData1_i);
  assign operand2 = pickOperand(hit2, wbData_i, rfData2_i);

  // killCkpt_i is already qualified by a verified mispredict.
  assign killed    = |(ckptMask_i & killCkpt_i);
  assign laneValid = issueValid_i & ~killed;

  // ********************
  // Output register
  // ********************

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      validQ <= 1'b0;
    end else begin
      validQ <= laneValid;
    end
  end

  always_ff @(posedge clk) begin
    data1Q   <= operand1;
    data2Q   <= operand2;
    payloadQ <= payload_i;
  end

  assign outValid_o   = validQ;
  assign outData1_o   = data1Q;
  assign outData2_o   = data2Q;
  assign outPayload_o = payloadQ;

endmodule

//--- verilog/readyScoreboard.sv
/*
 * Ready scoreboard with one bit per physical register. Unmap clears a bit,
 * wakeup sets it, and an exception restores the architectural set.
 */
`timescale 1ns/1ps

module readyScoreboard #(
  parameter int NUM_LANES = regReadPkg::DEF_NUM_LANES,
  parameter int NUM_PHYS  = regReadPkg::DEF_NUM_PHYS,
  parameter int NUM_ARCH  = regReadPkg::DEF_NUM_ARCH,
  localparam int TAG_W    = $clog2(NUM_PHYS)
) (
  input  logic                             clk,
  input  logic                             rstN_i,
  input  logic                             exception_i,
  input  logic [NUM_LANES-1:0]             unmapValid_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]  unmapTag_i,
  input  logic [NUM_LANES-1:0]             wakeValid_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]  wakeTag_i,
  output logic [NUM_PHYS-1:0]              ready_o
);

  // Low NUM_ARCH registers hold the committed state.
  localparam logic [NUM_PHYS-1:0] ARCH_SET = ~({NUM_PHYS{1'b1}} << NUM_ARCH);

  logic [NUM_PHYS-1:0] readyQ;
  logic [NUM_PHYS-1:0] clearMask;
  logic [NUM_PHYS-1:0] setMask;
  logic [NUM_PHYS-1:0] readyNext;

  // ********************
  // Update masks
  // ********************

  always_comb begin
    clearMask = '0;
    setMask   = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmapValid_i[l]) begin
        clearMask[unmapTag_i[l]] = 1'b1;
      end
      if (wakeValid_i[l]) begin
        setMask[wakeTag_i[l]] = 1'b1;
      end
    end
  end

  // A wakeup beats an unmap of the same tag.
  assign readyNext = (readyQ & ~clearMask) | setMask;

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      readyQ <= ARCH_SET;
    end else if (exception_i) begin
      readyQ <= ARCH_SET;
    end else begin
      readyQ <= readyNext;
    end
  end

  assign ready_o = readyQ;

endmodule

//--- verilog/regReadStage.sv
/*
 * Register-read stage of the out-of-order core. Reads and forwards both
 * operands per lane, squashes mispredicted lanes and tracks register readiness.
 */
`timescale 1ns/1ps

module regReadStage #(
  parameter int NUM_LANES = regReadPkg::DEF_NUM_LANES,
  parameter int NUM_PHYS  = regReadPkg::DEF_NUM_PHYS,
  parameter int NUM_ARCH  = regReadPkg::DEF_NUM_ARCH,
  parameter int DATA_W    = regReadPkg::DEF_DATA_W,
  parameter int NUM_CKPT  = regReadPkg::DEF_NUM_CKPT,
  localparam int TAG_W    = $clog2(NUM_PHYS),
  localparam int CKPT_W   = (NUM_CKPT > 1) ? $clog2(NUM_CKPT) : 1
) (
  input  logic                                  clk,
  input  logic                                  rstN_i,

  // Issue.
  input  logic [NUM_LANES-1:0]                  issueValid_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]       srcTag1_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]       srcTag2_i,
  input  logic [NUM_LANES-1:0][NUM_CKPT-1:0]    ckptMask_i,
  input  regReadPkg::payload_t [NUM_LANES-1:0]  payload_i,

  // Write-back.
  input  logic [NUM_LANES-1:0]                  wbValid_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]       wbTag_i,
  input  logic [NUM_LANES-1:0][DATA_W-1:0]      wbData_i,

  // Branch resolution.
  input  logic                                  ctrlVerified_i,
  input  logic                                  ctrlMispredict_i,
  input  logic [CKPT_W-1:0]                     ctrlCkpt_i,

  // Scoreboard updates.
  input  logic [NUM_LANES-1:0]                  unmapValid_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]       unmapTag_i,
  input  logic [NUM_LANES-1:0]                  wakeValid_i,
  input  logic [NUM_LANES-1:0][TAG_W-1:0]       wakeTag_i,

  input  logic                                  recover_i,
  input  logic                                  exception_i,

  output logic [NUM_LANES-1:0]                  outValid_o,
  output logic [NUM_LANES-1:0][DATA_W-1:0]      outData1_o,
  output logic [NUM_LANES-1:0][DATA_W-1:0]      outData2_o,
  output regReadPkg::payload_t [NUM_LANES-1:0]  outPayload_o,
  output logic [NUM_PHYS-1:0]                   phyRegReady_o
);

  logic [NUM_LANES-1:0]             rfWrEn;
  logic [NUM_LANES-1:0][DATA_W-1:0] rfData1;
  logic [NUM_LANES-1:0][DATA_W-1:0] rfData2;
  logic                             mispredictKill;
  logic [NUM_CKPT-1:0]              ckptSel;
  logic [NUM_CKPT-1:0]              killCkpt;

  // ********************
  // Register file
  // ********************

  // No architectural writes while recovery is in progress.
  assign rfWrEn = wbValid_i & ~{NUM_LANES{recover_i}};

  physRegFile #(
    .NUM_LANES (NUM_LANES),
    .NUM_PHYS  (NUM_PHYS),
    .DATA_W    (DATA_W)
  ) regFile (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .wrEn_i    (rfWrEn),
    .wrTag_i   (wbTag_i),
    .wrData_i  (wbData_i),
    .rdTag1_i  (srcTag1_i),
    .rdTag2_i  (srcTag2_i),
    .rdData1_o (rfData1),
    .rdData2_o (rfData2)
  );

  // ********************
  // Mispredict decode
  // ********************

  assign mispredictKill = ctrlVerified_i & ctrlMispredict_i;

  always_comb begin
    for (int c = 0; c < NUM_CKPT; c++) begin
      ckptSel[c] = (ctrlCkpt_i == CKPT_W'(c));
    end
  end

  assign killCkpt = ckptSel & {NUM_CKPT{mispredictKill}};

  // ********************
  // Issue lanes
  // ********************

  for (genvar l = 0; l < NUM_LANES; l++) begin : genLane
    readLane #(
      .NUM_LANES (NUM_LANES),
      .NUM_PHYS  (NUM_PHYS),
      .DATA_W    (DATA_W),
      .NUM_CKPT  (NUM_CKPT)
    ) lane (
      .clk          (clk),
      .rstN_i       (rstN_i),
      .issueValid_i (issueValid_i[l]),
      .srcTag1_i    (srcTag1_i[l]),
      .srcTag2_i    (srcTag2_i[l]),
      .ckptMask_i   (ckptMask_i[l]),
      .payload_i    (payload_i[l]),
      .rfData1_i    (rfData1[l]),
      .rfData2_i    (rfData2[l]),
      .wbValid_i    (wbValid_i),
      .wbTag_i      (wbTag_i),
      .wbData_i     (wbData_i),
      .killCkpt_i   (killCkpt),
      .outValid_o   (outValid_o[l]),
      .outData1_o   (outData1_o[l]),
      .outData2_o   (outData2_o[l]),
      .outPayload_o (outPayload_o[l])
    );
  end

  readyScoreboard #(
    .NUM_LANES (NUM_LANES),
    .NUM_PHYS  (NUM_PHYS),
    .NUM_ARCH  (NUM_ARCH)
  ) scoreboard (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .exception_i  (exception_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .wakeValid_i  (wakeValid_i),
    .wakeTag_i    (wakeTag_i),
    .ready_o      (phyRegReady_o)
  );

endmodule

//--- tests/regReadStage_checker.sv
/*
 * Assertions on the register-read stage: reset, squash and exception restore.
 */
`timescale 1ns/1ps

module regReadStage_checker #(
  parameter int NUM_LANES = regReadPkg::DEF_NUM_LANES,
  parameter int NUM_PHYS  = regReadPkg::DEF_NUM_PHYS,
  parameter int NUM_ARCH  = regReadPkg::DEF_NUM_ARCH,
  parameter int NUM_CKPT  = regReadPkg::DEF_NUM_CKPT,
  localparam int CKPT_W   = (NUM_CKPT > 1) ? $clog2(NUM_CKPT) : 1
) (
  input logic                               clk,
  input logic                               rstN_i,
  input logic [NUM_LANES-1:0][NUM_CKPT-1:0] ckptMask_i,
  input logic                               ctrlVerified_i,
  input logic                               ctrlMispredict_i,
  input logic [CKPT_W-1:0]                  ctrlCkpt_i,
  input logic                               exception_i,
  input logic [NUM_LANES-1:0]               outValid_i,
  input logic [NUM_PHYS-1:0]                phyRegReady_i
);

  assert property (@(posedge clk) !rstN_i |-> (outValid_i == '0))
    else $error("Output valid while in reset.");

  for (genvar l = 0; l < NUM_LANES; l++) begin : genKill
    assert property (@(posedge clk) disable iff (!rstN_i)
      (ctrlVerified_i && ctrlMispredict_i && ckptMask_i[l][ctrlCkpt_i]) |=> !outValid_i[l])
      else $error("Killed lane %0d is valid.", l);
  end

  // Committed registers must be ready again after an exception.
  assert property (@(posedge clk) disable iff (!rstN_i)
    exception_i |=> (&phyRegReady_i[NUM_ARCH-1:0]))
    else $error("Architectural ready bits not restored after exception.");

endmodule

bind regReadStage regReadStage_checker #(
  .NUM_LANES (NUM_LANES),
  .NUM_PHYS  (NUM_PHYS),
  .NUM_ARCH  (NUM_ARCH),
  .NUM_CKPT  (NUM_CKPT)
) stageChecker (
  .clk              (clk),
  .rstN_i           (rstN_i),
  .ckptMask_i       (ckptMask_i),
  .ctrlVerified_i   (ctrlVerified_i),
  .ctrlMispredict_i (ctrlMispredict_i),
  .ctrlCkpt_i       (ctrlCkpt_i),
  .exception_i      (exception_i),
  .outValid_i       (outValid_o),
  .phyRegReady_i    (phyRegReady_o)
);

//--- tests/regReadTb.sv
/*
 * Testbench for the register-read stage: directed tests, a random mix and a reference model.
 */
`timescale 1ns/1ps

module regReadTb;

  import regReadPkg::*;

  localparam int NUM_LANES = DEF_NUM_LANES;
  localparam int NUM_PHYS  = DEF_NUM_PHYS;
  localparam int NUM_ARCH  = DEF_NUM_ARCH;
  localparam int DATA_W    = DEF_DATA_W;
  localparam int NUM_CKPT  = DEF_NUM_CKPT;
  localparam int TAG_W     = $clog2(NUM_PHYS);
  localparam int CKPT_W    = (NUM_CKPT > 1) ? $clog2(NUM_CKPT) : 1;
  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 40;
  localparam int RANDOM_CYCLES   = 300;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

  logic clk;
  logic rstN_i;
  logic [NUM_LANES-1:0]               issueValid_i;
  logic [NUM_LANES-1:0][TAG_W-1:0]    srcTag1_i;
  logic [NUM_LANES-1:0][TAG_W-1:0]    srcTag2_i;
  logic [NUM_LANES-1:0][NUM_CKPT-1:0] ckptMask_i;
  payload_t [NUM_LANES-1:0]           payload_i;
  logic [NUM_LANES-1:0]               wbValid_i;
  logic [NUM_LANES-1:0][TAG_W-1:0]    wbTag_i;
  logic [NUM_LANES-1:0][DATA_W-1:0]   wbData_i;
  logic                               ctrlVerified_i;
  logic                               ctrlMispredict_i;
  logic [CKPT_W-1:0]                  ctrlCkpt_i;
  logic [NUM_LANES-1:0]               unmapValid_i;
  logic [NUM_LANES-1:0][TAG_W-1:0]    unmapTag_i;
  logic [NUM_LANES-1:0]               wakeValid_i;
  logic [NUM_LANES-1:0][TAG_W-1:0]    wakeTag_i;
  logic                               recover_i;
  logic                               exception_i;
  logic [NUM_LANES-1:0]               outValid_o;
  logic [NUM_LANES-1:0][DATA_W-1:0]   outData1_o;
  logic [NUM_LANES-1:0][DATA_W-1:0]   outData2_o;
  payload_t [NUM_LANES-1:0]           outPayload_o;
  logic [NUM_PHYS-1:0]                phyRegReady_o;

  // Reference state and the prediction for the next edge.
  logic [DATA_W-1:0]   refRegs [NUM_PHYS];
  logic [NUM_PHYS-1:0] refReady;
  logic [NUM_LANES-1:0] expValid;
  logic [DATA_W-1:0]   expData1 [NUM_LANES];
  logic [DATA_W-1:0]   expData2 [NUM_LANES];
  payload_t            expPayload [NUM_LANES];
  string               testName;
  string               expName;
  int                  errorCount = 0;
  int                  checkCount = 0;
  logic [15:0]         lfsrState = 16'd58;

  regReadStage #(
    .NUM_LANES (NUM_LANES), .NUM_PHYS (NUM_PHYS), .NUM_ARCH (NUM_ARCH),
    .DATA_W (DATA_W), .NUM_CKPT (NUM_CKPT)
  ) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ********************
  // Reference model
  // ********************

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsrState[0]};
      lfsrState = lfsrState >> 1;
      if (value[0]) begin
        lfsrState = lfsrState ^ 16'hB400;
      end
    end
    return value;
  endfunction

  function automatic logic [NUM_PHYS-1:0] archSet();
    logic [NUM_PHYS-1:0] mask;
    mask = '0;
    for (int p = 0; p < NUM_ARCH; p++) begin
      mask[p] = 1'b1;
    end
    return mask;
  endfunction

  // First matching write-back lane, else the register array.
  function automatic logic [DATA_W-1:0] expectedOperand(input logic [TAG_W-1:0] tag);
    logic [DATA_W-1:0] value;
    logic found;
    value = refRegs[tag];
    found = 1'b0;
    for (int w = 0; w < NUM_LANES; w++) begin
      if (!found && wbValid_i[w] && wbTag_i[w] == tag) begin
        value = wbData_i[w];
        found = 1'b1;
      end
    end
    return value;
  endfunction

  function automatic logic [NUM_PHYS-1:0] expectedReady(input logic [NUM_PHYS-1:0] cur);
    logic [NUM_PHYS-1:0] next;
    next = cur;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmapValid_i[l]) begin
        next[unmapTag_i[l]] = 1'b0;
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wakeValid_i[l]) begin
        next[wakeTag_i[l]] = 1'b1;
      end
    end
    return exception_i ? archSet() : next;
  endfunction

  task automatic reportMismatch(input string field, input logic [63:0] expVal,
                                input logic [63:0] actVal);
    errorCount++;
    $display("FAIL %s %s: expected %0h, actual %0h", expName, field, expVal, actVal);
  endtask

  // ********************
  // Comparison
  // ********************

  // Inputs are stable at the falling edge, outputs reflect the last rising edge.
  always @(negedge clk) begin
    if (rstN_i) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        checkCount++;
        if (outValid_o[l] !== expValid[l]) begin
          reportMismatch($sformatf("lane%0d valid", l), 64'(expValid[l]), 64'(outValid_o[l]));
        end
        if (expValid[l] && outData1_o[l] !== expData1[l]) begin
          reportMismatch($sformatf("lane%0d data1", l), 64'(expData1[l]), 64'(outData1_o[l]));
        end
        if (expValid[l] && outData2_o[l] !== expData2[l]) begin
          reportMismatch($sformatf("lane%0d data2", l), 64'(expData2[l]), 64'(outData2_o[l]));
        end
        if (expValid[l] && outPayload_o[l] !== expPayload[l]) begin
          reportMismatch($sformatf("lane%0d payload", l), 64'(expPayload[l]),
                         64'(outPayload_o[l]));
        end
      end
      if (phyRegReady_o !== refReady) begin
        reportMismatch("phyRegReady", 64'(refReady), 64'(phyRegReady_o));
      end
      expName = testName;
      for (int l = 0; l < NUM_LANES; l++) begin
        expValid[l]   = issueValid_i[l] &&
                        !(ctrlVerified_i && ctrlMispredict_i && ckptMask_i[l][ctrlCkpt_i]);
        expData1[l]   = expectedOperand(srcTag1_i[l]);
        expData2[l]   = expectedOperand(srcTag2_i[l]);
        expPayload[l] = payload_i[l];
      end
      refReady = expectedReady(refReady);
      for (int w = 0; w < NUM_LANES; w++) begin
        if (!recover_i && wbValid_i[w]) begin
          refRegs[wbTag_i[w]] = wbData_i[w];
        end
      end
    end
  end

  // ********************
  // Stimulus
  // ********************

  task automatic driveIdle();
    {issueValid_i, srcTag1_i, srcTag2_i, ckptMask_i, payload_i} = '0;
    {wbValid_i, wbTag_i, wbData_i, unmapValid_i, unmapTag_i, wakeValid_i, wakeTag_i} = '0;
    {ctrlVerified_i, ctrlMispredict_i, ctrlCkpt_i, recover_i, exception_i} = '0;
  endtask

  task automatic startCycle(input string name);
    @(posedge clk);
    #1;
    driveIdle();
    testName = name;
  endtask

  task automatic issueLane(input int l, input int tag1, input int tag2, input int mask);
    issueValid_i[l] = 1'b1;
    srcTag1_i[l]    = TAG_W'(tag1);
    srcTag2_i[l]    = TAG_W'(tag2);
    ckptMask_i[l]   = NUM_CKPT'(mask);
    payload_i[l]    = PAYLOAD_W'(16'hA000 + l * 16 + tag1);
  endtask

  task automatic writeBack(input int l, input int tag, input logic [DATA_W-1:0] data);
    wbValid_i[l] = 1'b1;
    wbTag_i[l]   = TAG_W'(tag);
    wbData_i[l]  = data;
  endtask

  task automatic randomMix(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      startCycle("randomMix");
      for (int l = 0; l < NUM_LANES; l++) begin
        issueValid_i[l] = 1'(randBits(1));
        srcTag1_i[l]    = TAG_W'(randBits(TAG_W));
        srcTag2_i[l]    = TAG_W'(randBits(TAG_W));
        ckptMask_i[l]   = NUM_CKPT'(randBits(NUM_CKPT));
        payload_i[l]    = PAYLOAD_W'(randBits(PAYLOAD_W));
        wbValid_i[l]    = 1'(randBits(1));
        wbTag_i[l]      = TAG_W'(randBits(TAG_W));
        wbData_i[l]     = DATA_W'(randBits(DATA_W));
        unmapValid_i[l] = (randBits(2) == 0);
        unmapTag_i[l]   = TAG_W'(randBits(TAG_W));
        wakeValid_i[l]  = (randBits(2) == 0);
        wakeTag_i[l]    = TAG_W'(randBits(TAG_W));
      end
      ctrlVerified_i   = 1'(randBits(1));
      ctrlMispredict_i = (randBits(2) == 0);
      ctrlCkpt_i       = CKPT_W'(randBits(CKPT_W));
      recover_i        = (randBits(3) == 0);
      exception_i      = (randBits(5) == 0);
    end
  endtask

  initial begin
    for (int p = 0; p < NUM_PHYS; p++) begin
      refRegs[p] = '0;
    end
    refReady = archSet();
    expValid = '0;
    expName  = "reset";
    testName = "reset";
    rstN_i   = 1'b0;
    driveIdle();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstN_i = 1'b1;
    if (phyRegReady_o !== archSet()) begin
      reportMismatch("phyRegReady", 64'(archSet()), 64'(phyRegReady_o));
    end
    if (outValid_o !== '0) begin
      reportMismatch("outValid", 64'(0), 64'(outValid_o));
    end

    startCycle("writeRead");
    writeBack(0, 40, 32'hA5A5_0001);
    writeBack(2, 41, 32'h5A5A_0002);
    startCycle("writeRead");
    issueLane(1, 40, 41, 0);
    issueLane(3, 41, 40, 0);

    startCycle("forwardSameCycle");
    issueLane(0, 45, 46, 0);
    writeBack(3, 45, 32'h0000_4545);
    writeBack(1, 46, 32'h1111_4646);
    writeBack(2, 46, 32'h2222_4646);
    // Highest write lane owns the array entry after a collision.
    startCycle("readAfterPriority");
    issueLane(2, 46, 45, 0);

    startCycle("recoverForward");
    recover_i = 1'b1;
    writeBack(0, 47, 32'hDEAD_0047);
    issueLane(2, 47, 40, 0);
    startCycle("recoverRead");
    issueLane(2, 47, 47, 0);

    startCycle("squash");
    issueLane(0, 40, 41, 4'b0001);
    issueLane(1, 41, 40, 4'b0010);
    issueLane(2, 45, 46, 4'b0100);
    issueLane(3, 46, 45, 4'b0110);
    ctrlVerified_i   = 1'b1;
    ctrlMispredict_i = 1'b1;
    ctrlCkpt_i       = CKPT_W'(2);
    startCycle("squashUnverified");
    for (int l = 0; l < NUM_LANES; l++) begin
      issueLane(l, 40 + l, 45, 4'b1111);
    end
    ctrlMispredict_i = 1'b1;
    ctrlCkpt_i       = CKPT_W'(3);

    startCycle("scoreboard");
    unmapValid_i = 4'b0001;
    unmapTag_i[0] = TAG_W'(5);
    wakeValid_i = 4'b0010;
    wakeTag_i[1] = TAG_W'(50);
    startCycle("setBeatsClear");
    {unmapValid_i, wakeValid_i} = {4'b0101, 4'b1000};
    unmapTag_i[2] = TAG_W'(50);
    unmapTag_i[0] = TAG_W'(7);
    wakeTag_i[3]  = TAG_W'(50);
    startCycle("exception");
    exception_i = 1'b1;
    wakeValid_i = 4'b0001;
    wakeTag_i[0] = TAG_W'(60);
    startCycle("afterException");

    randomMix(RANDOM_CYCLES);
    startCycle("drain");
    repeat (2) @(posedge clk);
    #1;
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

//--- verilog.f
common/regReadPkg.sv
regfile/physRegFile.sv
verilog/readLane.sv
verilog/readyScoreboard.sv
verilog/regReadStage.sv
tests/regReadStage_checker.sv
tests/regReadTb.sv

//--- run.sh
#!/bin/sh
# Build and run the register-read stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module regReadTb -f verilog.f

status=0
./obj_dir/VregReadTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
echo "Simulation passed"
